//--- Bender.yml
package:
  name: mem_subsys

sources:
  - src/mem_pkg.sv
  - src/mem_arbiter.sv
  - src/mem_bus_seq.sv
  - src/mem_subsys.sv
  - target: test
    files:
      - tests/ram_model.sv
      - tests/tb_mem_subsys.sv

//--- mem_subsys.f
src/mem_pkg.sv
src/mem_arbiter.sv
src/mem_bus_seq.sv
src/mem_subsys.sv
tests/ram_model.sv
tests/tb_mem_subsys.sv

//--- src/mem_arbiter.sv
// fetch / data bus arbiter
`timescale 1ns/1ps

module mem_arbiter (
    input  logic              clk_in,
    input  logic              arst_n,
    input  logic              rdy_in,
    input  logic              clr,
    input  logic              fetch_req,
    input  mem_pkg::addr_t    fetch_addr,
    input  logic              data_req,
    input  mem_pkg::mem_req_t data_cmd,
    input  logic              seq_busy,
    input  mem_pkg::mem_rsp_t seq_rsp,
    output logic              seq_start,
    output mem_pkg::mem_req_t seq_req,
    output mem_pkg::mem_rsp_t fetch_rsp,
    output mem_pkg::mem_rsp_t data_rsp
);

    import mem_pkg::*;

    // pending slots, one per requester
    logic     fetch_pend_q;
    addr_t    fetch_addr_q;
    logic     data_pend_q;
    mem_req_t data_cmd_q;

    // 1 when data got the last grant, resets to fetch
    logic     last_data_q;
    // owner of the transfer in flight, 1 for data
    logic     owner_data_q;
    // in-flight fetch squashed by clr
    logic     fetch_kill_q;

    logic     fetch_ok;
    logic     grant_data;
    mem_req_t fetch_cmd;

    // a fetch in the clr cycle is never granted
    assign fetch_ok = fetch_pend_q && !clr;

    // on a tie the side not granted last wins
    assign grant_data = data_pend_q && (!fetch_ok || !last_data_q);

    assign seq_start = (fetch_ok || data_pend_q) && !seq_busy && rdy_in;

    // fetch is always an unsigned word read
    assign fetch_cmd = '{
        addr:      fetch_addr_q,
        wdata:     '0,
        len:       len_word,
        write:     1'b0,
        is_signed: 1'b0
    };

    assign seq_req = grant_data ? data_cmd_q : fetch_cmd;

    // completion goes to the owner, squashed fetches drop their done
    assign fetch_rsp.done  = seq_rsp.done && !owner_data_q && !fetch_kill_q && !clr;
    assign fetch_rsp.rdata = seq_rsp.rdata;
    assign data_rsp.done   = seq_rsp.done && owner_data_q;
    assign data_rsp.rdata  = seq_rsp.rdata;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pend_q <= 1'b0;
            data_pend_q  <= 1'b0;
            last_data_q  <= 1'b0;
            owner_data_q <= 1'b0;
            fetch_kill_q <= 1'b0;
        end else if (rdy_in) begin
            // fetch slot, a strobe together with clr is dropped
            if (fetch_req && !clr) begin
                fetch_pend_q <= 1'b1;
            end else if (clr || (seq_start && !grant_data)) begin
                fetch_pend_q <= 1'b0;
            end

            // data slot, never touched by clr
            if (data_req) begin
                data_pend_q <= 1'b1;
            end else if (seq_start && grant_data) begin
                data_pend_q <= 1'b0;
            end

            if (seq_start) begin
                owner_data_q <= grant_data;
                last_data_q  <= grant_data;
                fetch_kill_q <= 1'b0;
            end else if (clr) begin
                // bus bytes still finish, only the done is hidden
                fetch_kill_q <= 1'b1;
            end
        end
    end

    // request payloads
    always_ff @(posedge clk_in) begin
        if (rdy_in && fetch_req) begin
            fetch_addr_q <= fetch_addr;
        end
        if (rdy_in && data_req) begin
            data_cmd_q <= data_cmd;
        end
    end

endmodule

//--- src/mem_bus_seq.sv
// byte bus sequencer
`timescale 1ns/1ps

module mem_bus_seq (
    input  logic              clk_in,
    input  logic              arst_n,
    input  logic              rdy_in,
    input  logic              seq_start,
    input  mem_pkg::mem_req_t seq_req,
    input  logic              io_buffer_full,
    input  logic [7:0]        mem_din,
    output logic              seq_busy,
    output mem_pkg::mem_rsp_t seq_rsp,
    output logic [7:0]        mem_dout,
    output mem_pkg::addr_t    mem_a,
    output logic              mem_wr
);

    import mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_xfer = 2'd1,
        st_done = 2'd2
    } seq_state_e;

    seq_state_e state_q;
    mem_req_t   req_q;
    logic [1:0] idx_q;

    // what was on the address bus last cycle, for read capture
    logic       rd_phase_q;
    logic [1:0] rd_idx_q;
    word_t      rd_buf;

    logic [1:0] last_idx;
    logic       is_io;
    logic       io_stall;
    logic       step;
    word_t      assembled;

    function automatic word_t extend(input word_t raw, input mem_len_e len, input logic sgn);
        word_t res;
        case (len)
            len_byte: res = {{24{sgn & raw[7]}}, raw[7:0]};
            len_half: res = {{16{sgn & raw[15]}}, raw[15:0]};
            default:  res = raw;
        endcase
        return res;
    endfunction

    // index of the final byte
    always_comb begin
        case (req_q.len)
            len_byte: last_idx = 2'd0;
            len_half: last_idx = 2'd1;
            default:  last_idx = 2'd3;
        endcase
    end

    assign is_io    = req_q.addr[17:16] == io_region;
    // io writes wait before each byte while the uart buffer is full
    assign io_stall = req_q.write && is_io && io_buffer_full;
    assign step     = rdy_in && (state_q == st_xfer) && !io_stall;

    // bus outputs
    assign mem_a    = (state_q == st_xfer) ? req_q.addr + addr_t'(idx_q) : '0;
    assign mem_wr   = step && req_q.write;
    assign mem_dout = (state_q == st_xfer && req_q.write) ?
                      req_q.wdata[{idx_q, 3'b000} +: 8] : 8'h00;

    // last read byte is still on mem_din in the first done cycle
    always_comb begin
        assembled = rd_buf;
        if (rd_phase_q) begin
            assembled[{rd_idx_q, 3'b000} +: 8] = mem_din;
        end
    end

    assign seq_rsp.done  = (state_q == st_done) && rdy_in;
    assign seq_rsp.rdata = req_q.write ? '0 : extend(assembled, req_q.len, req_q.is_signed);

    // free again in the cycle that done rises
    assign seq_busy = (state_q != st_idle) && !seq_rsp.done;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            idx_q   <= 2'd0;
        end else if (rdy_in) begin
            case (state_q)
                st_idle: begin
                    if (seq_start) begin
                        state_q <= st_xfer;
                        idx_q   <= 2'd0;
                    end
                end
                st_xfer: begin
                    if (!io_stall) begin
                        if (idx_q == last_idx) begin
                            state_q <= st_done;
                        end else begin
                            idx_q <= idx_q + 2'd1;
                        end
                    end
                end
                st_done: begin
                    // back to back transfer straight from done
                    if (seq_start) begin
                        state_q <= st_xfer;
                        idx_q   <= 2'd0;
                    end else begin
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // request held for the whole transfer
    always_ff @(posedge clk_in) begin
        if (rdy_in && seq_start && !seq_busy) begin
            req_q <= seq_req;
        end
    end

    // follows the device every cycle, pause or not,
    // so read data lines up with the address it came from
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            rd_phase_q <= 1'b0;
            rd_idx_q   <= 2'd0;
        end else begin
            rd_phase_q <= (state_q == st_xfer) && !req_q.write;
            rd_idx_q   <= idx_q;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rd_phase_q) begin
            rd_buf[{rd_idx_q, 3'b000} +: 8] <= mem_din;
        end
    end

endmodule

//--- src/mem_pkg.sv
// memory subsystem shared types

package mem_pkg;

    // byte address, only bits 17:0 reach the device
    typedef logic [31:0] addr_t;

    // data word as seen by the requesters
    typedef logic [31:0] word_t;

    // transfer length in bytes: 1, 2 or 4
    typedef enum logic [1:0] {
        len_byte = 2'd0,
        len_half = 2'd1,
        len_word = 2'd2
    } mem_len_e;

    // one bus request, from fetch or from the data side
    typedef struct packed {
        addr_t    addr;
        word_t    wdata;
        mem_len_e len;
        logic     write;
        // loads only, extends the top bit of a byte or halfword
        logic     is_signed;
    } mem_req_t;

    // one completion, rdata valid in the done cycle
    typedef struct packed {
        logic  done;
        word_t rdata;
    } mem_rsp_t;

    // mem_a[17:16] value of the uart / cycle counter range
    localparam logic [1:0] io_region = 2'b11;

endpackage

//--- src/mem_subsys.sv
// memory subsystem top
`timescale 1ns/1ps

module mem_subsys (
    input  logic              clk_in,
    input  logic              arst_n,
    input  logic              rdy_in,
    input  logic              clr,

    // fetch side
    input  logic              fetch_req,
    input  mem_pkg::addr_t    fetch_addr,
    output mem_pkg::mem_rsp_t fetch_rsp,

    // data side
    input  logic              data_req,
    input  mem_pkg::mem_req_t data_cmd,
    output mem_pkg::mem_rsp_t data_rsp,

    // device bus
    input  logic [7:0]        mem_din,
    input  logic              io_buffer_full,
    output logic [7:0]        mem_dout,
    output mem_pkg::addr_t    mem_a,
    output logic              mem_wr
);

    import mem_pkg::*;

    logic     seq_start;
    logic     seq_busy;
    mem_req_t seq_req;
    mem_rsp_t seq_rsp;

    mem_arbiter u_mem_arbiter (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .rdy_in    (rdy_in),
        .clr       (clr),
        .fetch_req (fetch_req),
        .fetch_addr(fetch_addr),
        .data_req  (data_req),
        .data_cmd  (data_cmd),
        .seq_busy  (seq_busy),
        .seq_rsp   (seq_rsp),
        .seq_start (seq_start),
        .seq_req   (seq_req),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp)
    );

    mem_bus_seq u_mem_bus_seq (
        .clk_in        (clk_in),
        .arst_n        (arst_n),
        .rdy_in        (rdy_in),
        .seq_start     (seq_start),
        .seq_req       (seq_req),
        .io_buffer_full(io_buffer_full),
        .mem_din       (mem_din),
        .seq_busy      (seq_busy),
        .seq_rsp       (seq_rsp),
        .mem_dout      (mem_dout),
        .mem_a         (mem_a),
        .mem_wr        (mem_wr)
    );

endmodule

//--- tests/ram_model.sv
// byte ram model with i/o write log
`timescale 1ns/1ps

module ram_model (
    input  logic           clk_in,
    input  mem_pkg::addr_t mem_a,
    input  logic [7:0]     mem_dout,
    input  logic           mem_wr,
    output logic [7:0]     mem_din
);

    import mem_pkg::*;

    // 128 KB, indexed by mem_a[16:0]
    logic [7:0] mem [0:131071];

    // bytes written into the i/o range, oldest first
    logic [7:0] io_log [$];

    logic is_io;

    assign is_io = mem_a[17:16] == io_region;

    always @(posedge clk_in) begin
        if (mem_wr) begin
            if (is_io) begin
                io_log.push_back(mem_dout);
            end else begin
                mem[mem_a[16:0]] <= mem_dout;
            end
        end
        // one cycle read latency
        mem_din <= mem[mem_a[16:0]];
    end

endmodule

//--- tests/tb_mem_subsys.sv
// mem_subsys testbench
`timescale 1ns/1ps

module tb_mem_subsys;

    import mem_pkg::*;

    typedef enum logic [2:0] {
        k_fetch, k_load, k_store, k_both, k_clr, k_io
    } kind_e;

    // hold is the io_buffer_full length or the clr delay for k_clr
    typedef struct packed {
        kind_e    kind;
        addr_t    addr;
        mem_len_e len;
        logic     sgn;
        int       pause;
        int       hold;
        word_t    wdata;
        word_t    exp;
    } step_t;

    logic       clk_in;
    logic       arst_n;
    logic       rdy_in;
    logic       clr;
    logic       fetch_req;
    addr_t      fetch_addr;
    mem_rsp_t   fetch_rsp;
    logic       data_req;
    mem_req_t   data_cmd;
    mem_rsp_t   data_rsp;
    logic [7:0] mem_din;
    logic       io_buffer_full;
    logic [7:0] mem_dout;
    addr_t      mem_a;
    logic       mem_wr;

    logic [7:0]  shadow [0:131071];
    step_t       steps [$];
    mem_rsp_t    fetch_q [$];
    mem_rsp_t    data_q [$];
    // 1 marks a data done and 0 a fetch done
    logic        order_q [$];
    int          errors;
    logic        last_data;

    mem_subsys u_mem_subsys (
        .clk_in        (clk_in),
        .arst_n        (arst_n),
        .rdy_in        (rdy_in),
        .clr           (clr),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .fetch_rsp     (fetch_rsp),
        .data_req      (data_req),
        .data_cmd      (data_cmd),
        .data_rsp      (data_rsp),
        .mem_din       (mem_din),
        .io_buffer_full(io_buffer_full),
        .mem_dout      (mem_dout),
        .mem_a         (mem_a),
        .mem_wr        (mem_wr)
    );

    ram_model u_ram (
        .clk_in  (clk_in),
        .mem_a   (mem_a),
        .mem_dout(mem_dout),
        .mem_wr  (mem_wr),
        .mem_din (mem_din)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    // collects done strobes and watches the stall rules
    always @(posedge clk_in) begin
        if (arst_n) begin
            if (fetch_rsp.done) begin
                fetch_q.push_back(fetch_rsp);
                order_q.push_back(1'b0);
            end
            if (data_rsp.done) begin
                data_q.push_back(data_rsp);
                order_q.push_back(1'b1);
            end
            if (!rdy_in && (mem_wr || fetch_rsp.done || data_rsp.done)) begin
                errors++;
                $display("bus activity at %0t while rdy_in is low", $time);
            end
            if (io_buffer_full && mem_wr && mem_a[17:16] == io_region) begin
                errors++;
                $display("I/O byte written at %0t while io_buffer_full is high", $time);
            end
        end
    end

    function automatic logic [7:0] pattern_byte(input int unsigned a);
        return 8'((a * 37) ^ (a >> 7) ^ (a >> 13));
    endfunction

    function automatic int len_bytes(input mem_len_e len);
        case (len)
            len_byte: return 1;
            len_half: return 2;
            default:  return 4;
        endcase
    endfunction

    // little-endian read with load extension
    function automatic word_t shadow_read(input addr_t a, input mem_len_e len, input logic sgn);
        word_t w;
        int    n;
        n = len_bytes(len);
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = shadow[a[16:0] + i];
        end
        if (sgn && w[8*n-1]) begin
            for (int i = n; i < 4; i++) begin
                w[8*i +: 8] = 8'hff;
            end
        end
        return w;
    endfunction

    task automatic check_rsp(input string name, input mem_rsp_t exp, input mem_rsp_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_ram_byte(input addr_t a, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: mem[%h] expected %h, actual %h", $time, a, exp, act);
        end
    endtask

    task automatic check_io_byte(input int idx, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: io_log[%0d] expected %h, actual %h", $time, idx, exp, act);
        end
    endtask

    task automatic check_winner(input logic exp_data, input logic act_data);
        if (act_data !== exp_data) begin
            errors++;
            $display("Error at %0t: first done expected %s, actual %s", $time,
                     exp_data ? "data" : "fetch", act_data ? "data" : "fetch");
        end
    endtask

    task automatic strobe(input logic f, input addr_t fa, input logic d, input mem_req_t cmd,
                          input logic c);
        @(negedge clk_in);
        fetch_req  = f;
        fetch_addr = fa;
        data_req   = d;
        data_cmd   = cmd;
        clr        = c;
        @(negedge clk_in);
        fetch_req = 1'b0;
        data_req  = 1'b0;
        clr       = 1'b0;
    endtask

    task automatic pause_bus(input int cycles);
        if (cycles > 0) begin
            @(negedge clk_in);
            rdy_in = 1'b0;
            repeat (cycles) @(negedge clk_in);
            rdy_in = 1'b1;
        end
    endtask

    task automatic wait_rsp(input logic from_data, output mem_rsp_t got);
        while ((from_data ? data_q.size() : fetch_q.size()) == 0) begin
            @(negedge clk_in);
        end
        got = from_data ? data_q.pop_front() : fetch_q.pop_front();
    endtask

    task automatic run_step(input step_t s);
        mem_req_t cmd;
        mem_rsp_t got;
        mem_rsp_t exp;
        mem_rsp_t fexp;
        addr_t    fa;
        int       n;
        int       log0;
        logic     data_first;
        n    = len_bytes(s.len);
        fa   = s.addr + 32'h100;
        cmd  = '{addr: s.addr, wdata: s.wdata, len: s.len,
                 write: s.kind == k_store || s.kind == k_io, is_signed: s.sgn};
        exp  = '{done: 1'b1, rdata: s.exp};
        fexp = '{done: 1'b1, rdata: shadow_read(fa, len_word, 1'b0)};
        log0 = u_ram.io_log.size();
        case (s.kind)
            k_fetch: begin
                strobe(1'b1, s.addr, 1'b0, cmd, 1'b0);
                pause_bus(s.pause);
                wait_rsp(1'b0, got);
                check_rsp("fetch_rsp", exp, got);
                last_data = 1'b0;
            end
            k_both: begin
                data_first = !last_data;
                strobe(1'b1, fa, 1'b1, cmd, 1'b0);
                wait_rsp(1'b1, got);
                check_rsp("data_rsp", exp, got);
                wait_rsp(1'b0, got);
                check_rsp("fetch_rsp", fexp, got);
                check_winner(data_first, order_q[0]);
                last_data = !data_first;
            end
            k_clr: begin
                if (s.hold == 0) begin
                    strobe(1'b1, fa, 1'b1, cmd, 1'b1);
                end else begin
                    // clr and the load arrive while the fetch is on the bus
                    strobe(1'b1, fa, 1'b0, cmd, 1'b0);
                    repeat (s.hold - 2) @(negedge clk_in);
                    strobe(1'b0, '0, 1'b1, cmd, 1'b1);
                end
                wait_rsp(1'b1, got);
                check_rsp("data_rsp", exp, got);
                last_data = 1'b1;
            end
            default: begin
                @(negedge clk_in);
                io_buffer_full = s.kind == k_io && s.hold > 0;
                strobe(1'b0, '0, 1'b1, cmd, 1'b0);
                pause_bus(s.pause);
                if (s.kind == k_io) begin
                    repeat (s.hold) @(negedge clk_in);
                    if (u_ram.io_log.size() != log0 || data_q.size() != 0) begin
                        errors++;
                        $display("I/O store finished at %0t while io_buffer_full was high", $time);
                    end
                    io_buffer_full = 1'b0;
                end
                wait_rsp(1'b1, got);
                if (!cmd.write) begin
                    check_rsp("data_rsp", exp, got);
                end
                if (s.kind == k_store) begin
                    for (int i = 0; i < n; i++) begin
                        shadow[s.addr[16:0] + i] = s.wdata[8*i +: 8];
                        check_ram_byte(s.addr + i, s.wdata[8*i +: 8], u_ram.mem[s.addr[16:0] + i]);
                    end
                end
                if (s.kind == k_io) begin
                    if (u_ram.io_log.size() != log0 + n) begin
                        errors++;
                        $display("I/O log gained %0d bytes instead of %0d at %0t",
                                 u_ram.io_log.size() - log0, n, $time);
                    end else begin
                        for (int i = 0; i < n; i++) begin
                            check_io_byte(log0 + i, s.wdata[8*i +: 8], u_ram.io_log[log0 + i]);
                        end
                    end
                end
                last_data = 1'b1;
            end
        endcase
        // anything left over is a done nobody asked for
        repeat (4) @(negedge clk_in);
        if (fetch_q.size() != 0) begin
            errors++;
            $display("unexpected fetch done before %0t", $time);
        end
        if (data_q.size() != 0) begin
            errors++;
            $display("unexpected data done before %0t", $time);
        end
        fetch_q.delete();
        data_q.delete();
        order_q.delete();
    endtask

    task automatic build_table();
        steps.push_back('{k_both,  32'h00400, len_word, 1'b0, 0, 0, '0, '0});
        steps.push_back('{k_store, 32'h00100, len_word, 1'b0, 0, 0, '0, '0});
        steps.push_back('{k_fetch, 32'h00100, len_word, 1'b0, 0, 0, '0, '0});
        steps.push_back('{k_both,  32'h00600, len_word, 1'b0, 0, 0, '0, '0});
        steps.push_back('{k_load,  32'h00700, len_word, 1'b0, 0, 0, '0, '0});
        steps.push_back('{k_both,  32'h00800, len_half, 1'b1, 0, 0, '0, '0});
        steps.push_back('{k_store, 32'h00204, len_half, 1'b0, 0, 0, '0, '0});
        steps.push_back('{k_load,  32'h00204, len_half, 1'b1, 0, 0, '0, '0});
        steps.push_back('{k_load,  32'h00204, len_half, 1'b0, 0, 0, '0, '0});
        steps.push_back('{k_store, 32'h00311, len_byte, 1'b0, 0, 0, '0, '0});
        steps.push_back('{k_load,  32'h00311, len_byte, 1'b1, 0, 0, '0, '0});
        steps.push_back('{k_load,  32'h00311, len_byte, 1'b0, 0, 0, '0, '0});
        steps.push_back('{k_load,  32'h1fff1, len_half, 1'b1, 0, 0, '0, '0});
        steps.push_back('{k_load,  32'h00900, len_word, 1'b0, 5, 0, '0, '0});
        steps.push_back('{k_store, 32'h00a00, len_word, 1'b0, 3, 0, '0, '0});
        steps.push_back('{k_fetch, 32'h00a00, len_word, 1'b0, 2, 0, '0, '0});
        steps.push_back('{k_io,    32'h30000, len_byte, 1'b0, 0, 6, '0, '0});
        steps.push_back('{k_io,    32'h30004, len_half, 1'b0, 0, 4, '0, '0});
        steps.push_back('{k_clr,   32'h00100, len_word, 1'b0, 0, 0, '0, '0});
        steps.push_back('{k_clr,   32'h00311, len_byte, 1'b1, 0, 3, '0, '0});
        steps.push_back('{k_fetch, 32'h00a00, len_word, 1'b0, 0, 0, '0, '0});
        steps.push_back('{k_both,  32'h00b00, len_word, 1'b0, 0, 0, '0, '0});
    endtask

    initial begin
        int limit;
        arst_n         = 1'b0;
        rdy_in         = 1'b1;
        clr            = 1'b0;
        fetch_req      = 1'b0;
        fetch_addr     = '0;
        data_req       = 1'b0;
        data_cmd       = '0;
        io_buffer_full = 1'b0;
        errors         = 0;
        last_data      = 1'b0;
        void'($urandom(92209));
        for (int a = 0; a < 131072; a++) begin
            shadow[a]    = pattern_byte(a);
            u_ram.mem[a] = shadow[a];
        end
        build_table();
        limit = 20;
        foreach (steps[k]) begin
            limit += 64 + steps[k].pause + steps[k].hold;
        end
        fork
            begin
                repeat (limit) @(posedge clk_in);
                $display("watchdog expired after %0d cycles, a done strobe never arrived", limit);
                $display("Finished with errors");
                $finish;
            end
        join_none
        repeat (10) @(posedge clk_in);
        @(negedge clk_in);
        arst_n = 1'b1;
        foreach (steps[k]) begin
            steps[k].wdata = $urandom;
            // short stores get their top bit set so signed and unsigned loads differ
            if (steps[k].kind == k_store && steps[k].len != len_word) begin
                steps[k].wdata[8*len_bytes(steps[k].len)-1] = 1'b1;
            end
            steps[k].exp   = shadow_read(steps[k].addr, steps[k].len, steps[k].sgn);
            run_step(steps[k]);
        end
        $display("steps: %0d, errors: %0d", steps.size(), errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
